// ==== source/csc_pkg.sv ====
package csc_pkg;

    // Input channel format, unsigned 8.IN_FRAC_W
    localparam int IN_INT_W      = 8;
    localparam int DEF_IN_FRAC_W = 6;

    // Output widths, Y is 8.4 and RGB uses the low 8 bits
    localparam int OUT_W    = 12;
    localparam int CHROMA_W = OUT_W + 1;

    // Shifted sum before clamping, large enough for any coefficient row
    localparam int SUM_W  = 16;
    localparam int COEF_W = 16;

    localparam int RGB_COEF_FRAC = 11;
    localparam int YCC_COEF_FRAC = 10;
    localparam int YCC_OUT_FRAC  = 4;

    typedef logic signed [COEF_W-1:0] coef_t;

    // Rows are output channels, columns are L, M, S
    localparam coef_t RGB_COEF [3][3] = '{
        '{ 16'sd8349, -16'sd6774,  16'sd473},
        '{-16'sd2598,  16'sd5345, -16'sd699},
        '{   -16'sd9, -16'sd1441,  16'sd3497}
    };

    localparam coef_t YCC_COEF [3][3] = '{
        '{  16'sd485,   16'sd474,  16'sd65},
        '{ -16'sd275,  -16'sd671,  16'sd946},
        '{ 16'sd2621, -16'sd2743,  16'sd122}
    };

    typedef enum logic {
        MODE_YCBCR = 1'b0,
        MODE_RGB   = 1'b1
    } conv_mode_e;

    // AXI4-Lite register map
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] CTRL_ADDR  = 4'h0;
    localparam int                    CTRL_MODE_BIT = 0;
    localparam int                    CTRL_OFFS_BIT = 1;
    localparam logic [1:0]            CTRL_RESET = 2'b00;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== source/csc_stage_if.sv ====
`timescale 1ns/1ps

interface csc_stage_if import csc_pkg::*; ();

    // Shifted matrix results, not yet clamped
    logic signed [SUM_W-1:0] ch_sum [3];

    // Settings the item entered with
    conv_mode_e mode;
    logic       chroma_offset;

    // Line markers, href doubles as the valid flag
    logic hstr;
    logic href;
    logic hend;

    modport pipe (
        output ch_sum,
        output mode,
        output chroma_offset,
        output hstr,
        output href,
        output hend
    );

    modport fmt (
        input ch_sum,
        input mode,
        input chroma_offset,
        input hstr,
        input href,
        input hend
    );

endinterface

// ==== source/csc_reg_block.sv ====
`timescale 1ns/1ps

module csc_reg_block import csc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,

    // Write address and data
    input  logic [AXI_ADDR_W-1:0]   i_awaddr,
    input  logic                    i_awvalid,
    output logic                    o_awready,
    input  logic [AXI_DATA_W-1:0]   i_wdata,
    input  logic [AXI_DATA_W/8-1:0] i_wstrb,
    input  logic                    i_wvalid,
    output logic                    o_wready,

    // Write response
    output logic [1:0]              o_bresp,
    output logic                    o_bvalid,
    input  logic                    i_bready,

    // Read address and data
    input  logic [AXI_ADDR_W-1:0]   i_araddr,
    input  logic                    i_arvalid,
    output logic                    o_arready,
    output logic [AXI_DATA_W-1:0]   o_rdata,
    output logic [1:0]              o_rresp,
    output logic                    o_rvalid,
    input  logic                    i_rready,

    // Conversion control
    output conv_mode_e              o_mode,
    output logic                    o_chroma_offset
);

    logic [1:0] ctrl_q;
    logic       wr_accept;
    logic       rd_accept;
    logic       aw_hit;
    logic       ar_hit;

    // Address and data are taken together, only while no response waits
    assign wr_accept = i_awvalid && i_wvalid && !o_bvalid;
    assign rd_accept = i_arvalid && !o_rvalid;

    assign o_awready = wr_accept;
    assign o_wready  = wr_accept;
    assign o_arready = rd_accept;

    assign aw_hit = (i_awaddr == CTRL_ADDR);
    assign ar_hit = (i_araddr == CTRL_ADDR);

    // Control register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= CTRL_RESET;
        end else if (wr_accept && aw_hit && i_wstrb[0]) begin
            ctrl_q <= i_wdata[1:0];
        end
    end

    assign o_mode          = conv_mode_e'(ctrl_q[CTRL_MODE_BIT]);
    assign o_chroma_offset = ctrl_q[CTRL_OFFS_BIT];

    // Write response channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_bvalid <= 1'b0;
            o_bresp  <= RESP_OKAY;
        end else if (wr_accept) begin
            o_bvalid <= 1'b1;
            o_bresp  <= aw_hit ? RESP_OKAY : RESP_SLVERR;
        end else if (i_bready) begin
            o_bvalid <= 1'b0;
        end
    end

    // Read response channel, unmapped reads return zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rvalid <= 1'b0;
            o_rresp  <= RESP_OKAY;
            o_rdata  <= '0;
        end else if (rd_accept) begin
            o_rvalid <= 1'b1;
            if (ar_hit) begin
                o_rresp <= RESP_OKAY;
                o_rdata <= {{(AXI_DATA_W-2){1'b0}}, ctrl_q};
            end else begin
                o_rresp <= RESP_SLVERR;
                o_rdata <= '0;
            end
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

endmodule

// ==== source/csc_matrix_pipe.sv ====
`timescale 1ns/1ps

module csc_matrix_pipe import csc_pkg::*; #(
    parameter int IN_FRAC_W = DEF_IN_FRAC_W
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_l,
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_m,
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_s,
    input  logic                          i_hstr,
    input  logic                          i_href,
    input  logic                          i_hend,
    input  conv_mode_e                    i_mode,
    input  logic                          i_chroma_offset,
    csc_stage_if.pipe                     stage
);

    localparam int IN_W   = IN_INT_W + IN_FRAC_W;
    localparam int PROD_W = IN_W + COEF_W + 1;
    localparam int ACC_W  = PROD_W + 2;

    localparam int RGB_SHIFT = RGB_COEF_FRAC + IN_FRAC_W;
    localparam int YCC_SHIFT = YCC_COEF_FRAC + IN_FRAC_W - YCC_OUT_FRAC;

    // Half of one output step, for round half up
    localparam logic signed [ACC_W-1:0] RGB_HALF = ACC_W'(1) << (RGB_SHIFT - 1);
    localparam logic signed [ACC_W-1:0] YCC_HALF = ACC_W'(1) << (YCC_SHIFT - 1);

    // Stage 1 holds the pixel and its settings
    logic [IN_W-1:0] pix_q [3];
    conv_mode_e      mode_s1;
    logic            offs_s1;
    logic [2:0]      mark_s1;

    // Stage 2 holds the products
    logic signed [COEF_W-1:0] coef_sel [3][3];
    logic signed [PROD_W-1:0] prod_q [3][3];
    conv_mode_e               mode_s2;
    logic                     offs_s2;
    logic [2:0]               mark_s2;

    // Stage 3 inputs
    logic signed [ACC_W-1:0] rnd_sum [3];
    logic signed [ACC_W-1:0] shifted [3];

    always_ff @(posedge clk) begin
        pix_q[0] <= i_l;
        pix_q[1] <= i_m;
        pix_q[2] <= i_s;
    end

    // Pick one coefficient row per channel from the item's own mode
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            for (int k = 0; k < 3; k++) begin
                coef_sel[c][k] = (mode_s1 == MODE_RGB) ? RGB_COEF[c][k] : YCC_COEF[c][k];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            for (int k = 0; k < 3; k++) begin
                prod_q[c][k] <= $signed({1'b0, pix_q[k]}) * coef_sel[c][k];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 3; c++) begin
            rnd_sum[c] = ACC_W'(prod_q[c][0]) + ACC_W'(prod_q[c][1]) + ACC_W'(prod_q[c][2]);
            if (mode_s2 == MODE_RGB) begin
                rnd_sum[c] = rnd_sum[c] + RGB_HALF;
                shifted[c] = rnd_sum[c] >>> RGB_SHIFT;
            end else if (c == 0) begin
                // Y has only positive weights
                rnd_sum[c] = rnd_sum[c] + YCC_HALF;
                shifted[c] = $signed($unsigned(rnd_sum[c]) >> YCC_SHIFT);
            end else begin
                rnd_sum[c] = rnd_sum[c] + YCC_HALF;
                shifted[c] = rnd_sum[c] >>> YCC_SHIFT;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            stage.ch_sum[c] <= shifted[c][SUM_W-1:0];
        end
    end

    // Settings and markers move with their pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_s1             <= MODE_YCBCR;
            offs_s1             <= 1'b0;
            mark_s1             <= 3'b000;
            mode_s2             <= MODE_YCBCR;
            offs_s2             <= 1'b0;
            mark_s2             <= 3'b000;
            stage.mode          <= MODE_YCBCR;
            stage.chroma_offset <= 1'b0;
            stage.hstr          <= 1'b0;
            stage.href          <= 1'b0;
            stage.hend          <= 1'b0;
        end else begin
            mode_s1             <= i_mode;
            offs_s1             <= i_chroma_offset;
            mark_s1             <= {i_hstr, i_href, i_hend};
            mode_s2             <= mode_s1;
            offs_s2             <= offs_s1;
            mark_s2             <= mark_s1;
            stage.mode          <= mode_s2;
            stage.chroma_offset <= offs_s2;
            stage.hstr          <= mark_s2[2];
            stage.href          <= mark_s2[1];
            stage.hend          <= mark_s2[0];
        end
    end

endmodule

// ==== source/csc_out_format.sv ====
`timescale 1ns/1ps

module csc_out_format import csc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    csc_stage_if.fmt            stage,
    output logic [OUT_W-1:0]    o_ch1,
    output logic [CHROMA_W-1:0] o_ch2,
    output logic [CHROMA_W-1:0] o_ch3,
    output logic                o_hstr,
    output logic                o_href,
    output logic                o_hend
);

    localparam int RGB_MAX = 255;
    localparam int Y_MAX   = 2**OUT_W - 1;
    localparam int C_MAX   = 2**(OUT_W-1) - 1;
    localparam int C_MIN   = -(2**(OUT_W-1));
    localparam int C_OFFS  = 2**(OUT_W-1);

    logic [OUT_W-1:0]        ch1_d;
    logic [CHROMA_W-1:0]     ch2_d;
    logic [CHROMA_W-1:0]     ch3_d;
    logic signed [SUM_W-1:0] c_offs;

    function automatic logic signed [SUM_W-1:0] clamp(
        input logic signed [SUM_W-1:0] v,
        input int                      lo,
        input int                      hi
    );
        if (v < lo) begin
            return SUM_W'(lo);
        end else if (v > hi) begin
            return SUM_W'(hi);
        end
        return v;
    endfunction

    // Offset moves chroma from signed to unsigned range
    assign c_offs = stage.chroma_offset ? SUM_W'(C_OFFS) : '0;

    always_comb begin
        if (stage.mode == MODE_RGB) begin
            ch1_d = OUT_W'(clamp(stage.ch_sum[0], 0, RGB_MAX));
            ch2_d = CHROMA_W'(clamp(stage.ch_sum[1], 0, RGB_MAX));
            ch3_d = CHROMA_W'(clamp(stage.ch_sum[2], 0, RGB_MAX));
        end else begin
            ch1_d = OUT_W'(clamp(stage.ch_sum[0], 0, Y_MAX));
            ch2_d = CHROMA_W'(clamp(stage.ch_sum[1], C_MIN, C_MAX) + c_offs);
            ch3_d = CHROMA_W'(clamp(stage.ch_sum[2], C_MIN, C_MAX) + c_offs);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_ch1  <= '0;
            o_ch2  <= '0;
            o_ch3  <= '0;
            o_hstr <= 1'b0;
            o_href <= 1'b0;
            o_hend <= 1'b0;
        end else begin
            o_ch1  <= ch1_d;
            o_ch2  <= ch2_d;
            o_ch3  <= ch3_d;
            o_hstr <= stage.hstr;
            o_href <= stage.href;
            o_hend <= stage.hend;
        end
    end

endmodule

// ==== source/lms2color_top.sv ====
`timescale 1ns/1ps

module lms2color_top import csc_pkg::*; #(
    parameter int IN_FRAC_W = DEF_IN_FRAC_W
) (
    input  logic                          clk,
    input  logic                          rst_n,

    // Pixel stream
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_l,
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_m,
    input  logic [IN_INT_W+IN_FRAC_W-1:0] i_s,
    input  logic                          i_hstr,
    input  logic                          i_href,
    input  logic                          i_hend,

    // AXI4-Lite control port
    input  logic [AXI_ADDR_W-1:0]         i_awaddr,
    input  logic                          i_awvalid,
    output logic                          o_awready,
    input  logic [AXI_DATA_W-1:0]         i_wdata,
    input  logic [AXI_DATA_W/8-1:0]       i_wstrb,
    input  logic                          i_wvalid,
    output logic                          o_wready,
    output logic [1:0]                    o_bresp,
    output logic                          o_bvalid,
    input  logic                          i_bready,
    input  logic [AXI_ADDR_W-1:0]         i_araddr,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    output logic [AXI_DATA_W-1:0]         o_rdata,
    output logic [1:0]                    o_rresp,
    output logic                          o_rvalid,
    input  logic                          i_rready,

    // Converted stream
    output logic [OUT_W-1:0]              o_ch1,
    output logic [CHROMA_W-1:0]           o_ch2,
    output logic [CHROMA_W-1:0]           o_ch3,
    output logic                          o_hstr,
    output logic                          o_href,
    output logic                          o_hend
);

    conv_mode_e mode;
    logic       chroma_offset;

    csc_stage_if stage_if ();

    csc_reg_block u_reg_block (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_awaddr        (i_awaddr),
        .i_awvalid       (i_awvalid),
        .o_awready       (o_awready),
        .i_wdata         (i_wdata),
        .i_wstrb         (i_wstrb),
        .i_wvalid        (i_wvalid),
        .o_wready        (o_wready),
        .o_bresp         (o_bresp),
        .o_bvalid        (o_bvalid),
        .i_bready        (i_bready),
        .i_araddr        (i_araddr),
        .i_arvalid       (i_arvalid),
        .o_arready       (o_arready),
        .o_rdata         (o_rdata),
        .o_rresp         (o_rresp),
        .o_rvalid        (o_rvalid),
        .i_rready        (i_rready),
        .o_mode          (mode),
        .o_chroma_offset (chroma_offset)
    );

    csc_matrix_pipe #(
        .IN_FRAC_W (IN_FRAC_W)
    ) u_matrix_pipe (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_l             (i_l),
        .i_m             (i_m),
        .i_s             (i_s),
        .i_hstr          (i_hstr),
        .i_href          (i_href),
        .i_hend          (i_hend),
        .i_mode          (mode),
        .i_chroma_offset (chroma_offset),
        .stage           (stage_if.pipe)
    );

    csc_out_format u_out_format (
        .clk    (clk),
        .rst_n  (rst_n),
        .stage  (stage_if.fmt),
        .o_ch1  (o_ch1),
        .o_ch2  (o_ch2),
        .o_ch3  (o_ch3),
        .o_hstr (o_hstr),
        .o_href (o_href),
        .o_hend (o_hend)
    );

endmodule

// ==== dv/lms2color_properties.sv ====
`timescale 1ns/1ps

module lms2color_properties (
    input logic clk,
    input logic rst_n,
    input logic i_hstr,
    input logic i_href,
    input logic i_hend,
    input logic o_hstr,
    input logic o_href,
    input logic o_hend,
    input logic o_bvalid,
    input logic i_bready,
    input logic o_rvalid,
    input logic i_rready
);

    // Responses wait for the manager
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_bvalid && !i_bready |=> o_bvalid)
        else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_rvalid && !i_rready |=> o_rvalid)
        else $error("rvalid dropped before rready");

    // Markers come out four cycles after they go in
    a_marker_delay: assert property (@(posedge clk) disable iff (!rst_n)
        {o_hstr, o_href, o_hend} == $past({i_hstr, i_href, i_hend}, 4))
        else $error("line markers not delayed by four cycles");

    a_marker_reset: assert property (@(posedge clk)
        !rst_n |-> {o_hstr, o_href, o_hend} == 3'b000)
        else $error("line markers active during reset");

endmodule

bind lms2color_top lms2color_properties u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_hstr   (i_hstr),
    .i_href   (i_href),
    .i_hend   (i_hend),
    .o_hstr   (o_hstr),
    .o_href   (o_href),
    .o_hend   (o_hend),
    .o_bvalid (o_bvalid),
    .i_bready (i_bready),
    .o_rvalid (o_rvalid),
    .i_rready (i_rready)
);

// ==== dv/tb_lms2color.sv ====
`timescale 1ns/1ps

module tb_lms2color import csc_pkg::*; ();

    localparam int IN_FRAC_W = DEF_IN_FRAC_W;
    localparam int IN_W      = IN_INT_W + IN_FRAC_W;
    localparam int PIX_MAX   = 2**IN_W - 1;
    localparam int LATENCY   = 4;

    // Planned test lengths in cycles, setup covers register traffic and drains
    localparam int N_RGB    = 300;
    localparam int N_YCC    = 300;
    localparam int N_MARK   = 300;
    localparam int N_SWITCH = 1000;
    localparam int N_SETUP  = 800;
    localparam int TIMEOUT_CYCLES = 2 * (N_RGB + 2 * N_YCC + N_MARK + N_SWITCH + N_SETUP);

    localparam logic [AXI_ADDR_W-1:0] BAD_ADDR = 4'h8;

    // Conversion matrices, rows are output channels, columns L, M, S
    localparam int RGB_K [3][3] = '{
        '{8349, -6774, 473}, '{-2598, 5345, -699}, '{-9, -1441, 3497}
    };
    localparam int YCC_K [3][3] = '{
        '{485, 474, 65}, '{-275, -671, 946}, '{2621, -2743, 122}
    };

    typedef struct packed {
        logic [OUT_W-1:0]    ch1;
        logic [CHROMA_W-1:0] ch2;
        logic [CHROMA_W-1:0] ch3;
        logic [2:0]          mark;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    logic [IN_W-1:0]         i_l, i_m, i_s;
    logic                    i_hstr, i_href, i_hend;
    logic [AXI_ADDR_W-1:0]   i_awaddr, i_araddr;
    logic                    i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
    logic [AXI_DATA_W-1:0]   i_wdata;
    logic [AXI_DATA_W/8-1:0] i_wstrb;
    logic                    o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
    logic [1:0]              o_bresp, o_rresp;
    logic [AXI_DATA_W-1:0]   o_rdata;
    logic [OUT_W-1:0]        o_ch1;
    logic [CHROMA_W-1:0]     o_ch2, o_ch3;
    logic                    o_hstr, o_href, o_hend;

    int                    seed = 32'hc3ad;
    int                    err_cnt = 0;
    int                    check_cnt = 0;
    int                    test_base = 0;
    int                    cycle_cnt = 0;
    expect_t               exp_q [$];
    logic [1:0]            ctrl_model = CTRL_RESET;
    logic                  wr_busy = 1'b0;
    logic                  rd_busy = 1'b0;
    logic [AXI_ADDR_W-1:0] wr_addr;
    logic [AXI_DATA_W-1:0] wr_data;
    logic [1:0]            last_bresp, last_rresp, resp;
    logic [AXI_DATA_W-1:0] last_rdata, rdata;

    lms2color_top DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic longint clip(input longint v, input longint lo, input longint hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // Matrix, round half up, arithmetic shift, clamp, then the chroma offset
    function automatic expect_t model_pixel(input int l, input int m, input int s,
                                            input logic [1:0] ctrl, input logic [2:0] mark);
        int      pix [3];
        longint  acc;
        longint  v;
        int      sh;
        expect_t e;
        pix = '{l, m, s};
        sh = ctrl[0] ? RGB_COEF_FRAC + IN_FRAC_W : YCC_COEF_FRAC + IN_FRAC_W - YCC_OUT_FRAC;
        for (int c = 0; c < 3; c++) begin
            acc = 0;
            for (int k = 0; k < 3; k++) begin
                acc += longint'(ctrl[0] ? RGB_K[c][k] : YCC_K[c][k]) * pix[k];
            end
            v = (acc + (longint'(1) <<< (sh - 1))) >>> sh;
            if (ctrl[0]) begin
                v = clip(v, 0, 255);
            end else if (c == 0) begin
                v = clip(v, 0, 4095);
            end else begin
                v = clip(v, -2048, 2047) + (ctrl[1] ? 2048 : 0);
            end
            if (c == 0) e.ch1 = v[OUT_W-1:0];
            else if (c == 1) e.ch2 = v[CHROMA_W-1:0];
            else e.ch3 = v[CHROMA_W-1:0];
        end
        e.mark = mark;
        return e;
    endfunction

    // One cycle: check the oldest entry, collect AXI responses, drive the next pixel
    task automatic tick(input int l, input int m, input int s, input logic [2:0] mark);
        expect_t want;
        @(negedge clk);
        if (exp_q.size() == LATENCY) begin
            want = exp_q.pop_front();
            check_value("o_ch1", want.ch1, o_ch1);
            check_value("o_ch2", want.ch2, o_ch2);
            check_value("o_ch3", want.ch3, o_ch3);
            check_value("o_hstr", want.mark[2], o_hstr);
            check_value("o_href", want.mark[1], o_href);
            check_value("o_hend", want.mark[0], o_hend);
        end
        // A response is left waiting one cycle after it is seen, then taken
        i_bready = o_bvalid && !wr_busy;
        i_rready = o_rvalid && !rd_busy;
        if (wr_busy && o_bvalid) begin
            // No new write is taken while the response waits
            check_value("o_awready", 0, o_awready);
            check_value("o_wready", 0, o_wready);
            // New setting applies from the pixel sampled on the next edge
            if (wr_addr == CTRL_ADDR) ctrl_model = wr_data[1:0];
            last_bresp = o_bresp;
            i_awvalid  = 1'b0;
            i_wvalid   = 1'b0;
            wr_busy    = 1'b0;
        end
        if (rd_busy && o_rvalid) begin
            check_value("o_arready", 0, o_arready);
            last_rdata = o_rdata;
            last_rresp = o_rresp;
            i_arvalid  = 1'b0;
            rd_busy    = 1'b0;
        end
        i_l = IN_W'(l);
        i_m = IN_W'(m);
        i_s = IN_W'(s);
        {i_hstr, i_href, i_hend} = mark;
        exp_q.push_back(model_pixel(l, m, s, ctrl_model, mark));
    endtask

    task automatic start_write(input logic [AXI_ADDR_W-1:0] addr,
                               input logic [AXI_DATA_W-1:0] data);
        i_awaddr  = addr;
        i_wdata   = data;
        i_wstrb   = '1;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        wr_addr   = addr;
        wr_data   = data;
        wr_busy   = 1'b1;
        // Address and data are both taken when no response waits
        #1;
        check_value("o_awready", 1, o_awready);
        check_value("o_wready", 1, o_wready);
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data, output logic [1:0] bresp);
        int n;
        while (o_bvalid) tick(0, 0, 0, 3'b000);
        start_write(addr, data);
        for (n = 0; n < 20 && wr_busy; n++) tick(0, 0, 0, 3'b000);
        if (wr_busy) begin
            $display("Write to address 0x%h got no response", addr);
            err_cnt++;
        end
        bresp = last_bresp;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data, output logic [1:0] rresp);
        int n;
        while (o_rvalid) tick(0, 0, 0, 3'b000);
        i_araddr  = addr;
        i_arvalid = 1'b1;
        rd_busy   = 1'b1;
        #1;
        check_value("o_arready", 1, o_arready);
        for (n = 0; n < 20 && rd_busy; n++) tick(0, 0, 0, 3'b000);
        if (rd_busy) begin
            $display("Read from address 0x%h got no response", addr);
            err_cnt++;
        end
        data  = last_rdata;
        rresp = last_rresp;
    endtask

    task automatic stream_pixels(input int count, input bit rand_marks);
        int         pix [3];
        logic [2:0] mark;
        for (int n = 0; n < count; n++) begin
            for (int k = 0; k < 3; k++) begin
                // Corner values push the sums into both clamps
                if (($random(seed) & 3) == 0) pix[k] = ($random(seed) & 1) ? PIX_MAX : 0;
                else pix[k] = $random(seed) & PIX_MAX;
            end
            if (rand_marks) mark = 3'($random(seed));
            else mark = {n == 0, 1'b1, n == count - 1};
            tick(pix[0], pix[1], pix[2], mark);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, err_cnt - test_base);
        test_base = err_cnt;
    endtask

    initial begin
        {clk, i_hstr, i_href, i_hend, i_awvalid, i_wvalid, i_arvalid} = '0;
        {i_l, i_m, i_s, i_awaddr, i_araddr, i_wdata, i_wstrb} = '0;
        i_bready = 1'b0;
        i_rready = 1'b0;
        rst_n    = 1'b1;
        #2;
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_value("o_ch1", 0, o_ch1);
        check_value("o_ch2", 0, o_ch2);
        check_value("o_ch3", 0, o_ch3);
        check_value("o_hstr/o_href/o_hend", 0, {o_hstr, o_href, o_hend});
        check_value("o_bvalid/o_rvalid", 0, {o_bvalid, o_rvalid});
        rst_n = 1'b1;
        axi_read(CTRL_ADDR, rdata, resp);
        check_value("rdata", 0, rdata);
        check_value("rresp", RESP_OKAY, resp);
        end_test("reset values");

        axi_write(CTRL_ADDR, 32'h3, resp);
        check_value("bresp", RESP_OKAY, resp);
        axi_read(CTRL_ADDR, rdata, resp);
        check_value("rdata", 32'h3, rdata);
        check_value("rresp", RESP_OKAY, resp);
        axi_write(CTRL_ADDR, 32'hffff_fffe, resp);
        axi_read(CTRL_ADDR, rdata, resp);
        check_value("rdata", 32'h2, rdata);
        axi_write(BAD_ADDR, 32'h1, resp);
        check_value("bresp", RESP_SLVERR, resp);
        axi_read(CTRL_ADDR, rdata, resp);
        check_value("rdata", 32'h2, rdata);
        axi_read(BAD_ADDR, rdata, resp);
        check_value("rdata", 0, rdata);
        check_value("rresp", RESP_SLVERR, resp);
        end_test("register access");

        axi_write(CTRL_ADDR, 32'h1, resp);
        stream_pixels(N_RGB, 1'b0);
        end_test("rgb conversion");

        axi_write(CTRL_ADDR, 32'h0, resp);
        stream_pixels(N_YCC, 1'b0);
        axi_write(CTRL_ADDR, 32'h2, resp);
        stream_pixels(N_YCC, 1'b0);
        end_test("ycbcr conversion");

        stream_pixels(N_MARK, 1'b1);
        end_test("marker delay");

        // Mode flips on every write while a pixel enters each cycle
        for (int n = 0; n < N_SWITCH; n++) begin
            if (n % 100 == 50 && !wr_busy && !o_bvalid) begin
                start_write(CTRL_ADDR, {30'd0, 1'($random(seed)), ~ctrl_model[0]});
            end
            stream_pixels(1, 1'b1);
        end
        while (wr_busy) tick(0, 0, 0, 3'b000);
        repeat (LATENCY) tick(0, 0, 0, 3'b000);
        end_test("mode change");

        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/csc_pkg.sv
source/csc_stage_if.sv
source/csc_reg_block.sv
source/csc_matrix_pipe.sv
source/csc_out_format.sv
source/lms2color_top.sv
dv/lms2color_properties.sv
dv/tb_lms2color.sv

// ==== Makefile ====
VERILATOR       ?= verilator
TOP             ?= tb_lms2color
SEED_LOG        ?= sim.log
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f tb.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f tb.f --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(SEED_LOG)
	@if grep -qxF '** PASS **' $(SEED_LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(SEED_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
